// ==== common/cpu_defs.svh ====
//////////////////////////////
// Core-wide constants
// Widths, register file size, RV32I opcodes and function codes
//////////////////////////////

`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data path and register file
`define XLEN       32
`define REG_COUNT  32
`define REG_IDX_W  5
`define ZERO_REG   5'd0

// Major opcodes, bits 6:0
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_SYSTEM  7'b1110011
// Decoded only so it can be rejected
`define OPC_STORE   7'b0100011

// funct3 codes of the integer ALU group
`define F3_ADD   3'b000
`define F3_SLL   3'b001
`define F3_SLT   3'b010
`define F3_SLTU  3'b011
`define F3_XOR   3'b100
`define F3_SR    3'b101
`define F3_OR    3'b110
`define F3_AND   3'b111

// funct7 alternate encoding (SUB, SRA) sits on funct7 bit 5
`define F7_ALT_BIT  5
`define F7_ALT      7'b0100000

// SYSTEM immediates that halt the core
`define SYS_ECALL   12'h000
`define SYS_EBREAK  12'h001
`define SYS_WFI     12'h105

`endif

// ==== common/cpu_pkg.sv ====
//////////////////////////////
// Core types
// Instruction word views and ALU operation codes
//////////////////////////////

`include "cpu_defs.svh"

package cpu_pkg;

    // Register-register format
    typedef struct packed {
        logic [6:0]            funct7;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`REG_IDX_W-1:0] rd;
        logic [6:0]            opcode;
    } r_type_t;

    // Register-immediate format, also SYSTEM
    typedef struct packed {
        logic [11:0]           imm;
        logic [`REG_IDX_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`REG_IDX_W-1:0] rd;
        logic [6:0]            opcode;
    } i_type_t;

    // Store format with split immediate
    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_type_t;

    // Upper-immediate format
    typedef struct packed {
        logic [19:0]           imm;
        logic [`REG_IDX_W-1:0] rd;
        logic [6:0]            opcode;
    } u_type_t;

    // One 32-bit word, four readings
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        u_type_t u;
    } inst_word_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B,
        ALU_ADD_PC
    } alu_op_t;

endpackage

// ==== hw/decode_stage.sv ====
//////////////////////////////
// Decode stage
// Takes one offered instruction, decodes fields, immediate,
// ALU operation, legality and halt into the decode register
//////////////////////////////

`timescale 1ns/1ps

`include "cpu_defs.svh"

module decode_stage import cpu_pkg::*; (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  ff_valid,
    input  inst_word_t            ff_instr,
    input  logic [`XLEN-1:0]      ff_pc,
    input  logic                  pipe_advance,
    output logic                  ff_consumed,
    output logic                  dec_valid,
    output alu_op_t               dec_alu_op,
    output logic [`REG_IDX_W-1:0] dec_rs1,
    output logic [`REG_IDX_W-1:0] dec_rs2,
    output logic [`REG_IDX_W-1:0] dec_rd,
    output logic                  dec_writes_rd,
    output logic                  dec_opb_imm,
    output logic [`XLEN-1:0]      dec_imm,
    output logic [`XLEN-1:0]      dec_pc,
    output logic                  dec_halt,
    output logic                  dec_illegal
);

    logic [6:0]       opcode;
    alu_op_t          alu_op;
    logic             opb_imm;
    logic [`XLEN-1:0] imm;
    logic             has_dest;
    logic             legal;
    logic             halt;
    logic             take;

    // funct3 plus alternate bit to ALU operation
    function automatic alu_op_t alu_from_f3(input logic [2:0] funct3, input logic alt);
        alu_op_t op;
        case (funct3)
            `F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            `F3_SLL:  op = ALU_SLL;
            `F3_SLT:  op = ALU_SLT;
            `F3_SLTU: op = ALU_SLTU;
            `F3_XOR:  op = ALU_XOR;
            `F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            `F3_OR:   op = ALU_OR;
            default:  op = ALU_AND;
        endcase
        return op;
    endfunction

    //////////////////////////////
    // Field decode
    //////////////////////////////

    // Opcode sits in the same bits for every view
    assign opcode = ff_instr.r.opcode;

    always_comb begin
        alu_op   = ALU_ADD;
        opb_imm  = 1'b0;
        imm      = '0;
        has_dest = 1'b0;
        legal    = 1'b0;
        halt     = 1'b0;
        case (opcode)
            `OPC_OP: begin
                has_dest = 1'b1;
                alu_op   = alu_from_f3(ff_instr.r.funct3, ff_instr.r.funct7[`F7_ALT_BIT]);
                // Alternate funct7 only for SUB and SRA
                legal    = (ff_instr.r.funct7 == 7'd0) ||
                           (ff_instr.r.funct7 == `F7_ALT &&
                            (ff_instr.r.funct3 == `F3_ADD || ff_instr.r.funct3 == `F3_SR));
            end
            `OPC_OP_IMM: begin
                has_dest = 1'b1;
                opb_imm  = 1'b1;
                imm      = {{(`XLEN - 12){ff_instr.i.imm[11]}}, ff_instr.i.imm};
                // ADDI has no alternate form, imm[11:5] is plain immediate there
                alu_op   = alu_from_f3(ff_instr.i.funct3,
                                       ff_instr.i.funct3 == `F3_SR &&
                                       ff_instr.i.imm[11:5] == `F7_ALT);
                if (ff_instr.i.funct3 == `F3_SLL) begin
                    legal = (ff_instr.i.imm[11:5] == 7'd0);
                end else if (ff_instr.i.funct3 == `F3_SR) begin
                    legal = (ff_instr.i.imm[11:5] == 7'd0) ||
                            (ff_instr.i.imm[11:5] == `F7_ALT);
                end else begin
                    legal = 1'b1;
                end
            end
            `OPC_LUI, `OPC_AUIPC: begin
                has_dest = 1'b1;
                opb_imm  = 1'b1;
                legal    = 1'b1;
                imm      = {ff_instr.u.imm, 12'd0};
                alu_op   = (opcode == `OPC_LUI) ? ALU_PASS_B : ALU_ADD_PC;
            end
            `OPC_SYSTEM: begin
                // ECALL, EBREAK, WFI only; CSR forms are rejected
                halt  = (ff_instr.i.funct3 == 3'd0) &&
                        (ff_instr.i.rs1 == `ZERO_REG) && (ff_instr.i.rd == `ZERO_REG) &&
                        (ff_instr.i.imm == `SYS_ECALL || ff_instr.i.imm == `SYS_EBREAK ||
                         ff_instr.i.imm == `SYS_WFI);
                legal = halt;
            end
            default: begin
                // Loads, stores and every other opcode are rejected
                legal = 1'b0;
            end
        endcase
    end

    //////////////////////////////
    // Intake and decode register
    //////////////////////////////

    // Accept when the slot is free or moves on this cycle
    assign ff_consumed = ff_valid && (!dec_valid || pipe_advance);
    assign take        = ff_consumed;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (take) begin
            dec_valid <= 1'b1;
        end else if (pipe_advance) begin
            dec_valid <= 1'b0;
        end
    end

    // Payload, loaded only on intake
    always_ff @(posedge clock) begin
        if (take) begin
            dec_alu_op    <= alu_op;
            dec_rs1       <= ff_instr.r.rs1;
            dec_rs2       <= ff_instr.r.rs2;
            dec_rd        <= ff_instr.r.rd;
            dec_writes_rd <= has_dest && legal && (ff_instr.r.rd != `ZERO_REG);
            dec_opb_imm   <= opb_imm;
            dec_imm       <= imm;
            dec_pc        <= ff_pc;
            dec_halt      <= halt;
            dec_illegal   <= !legal;
        end
    end

endmodule

// ==== hw/execute_stage.sv ====
//////////////////////////////
// Execute stage
// Operand select, integer ALU, execute register
//////////////////////////////

`timescale 1ns/1ps

`include "cpu_defs.svh"

module execute_stage import cpu_pkg::*; (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  pipe_advance,
    input  logic                  dec_valid,
    input  alu_op_t               dec_alu_op,
    input  logic [`REG_IDX_W-1:0] dec_rd,
    input  logic                  dec_writes_rd,
    input  logic                  dec_opb_imm,
    input  logic [`XLEN-1:0]      dec_imm,
    input  logic [`XLEN-1:0]      dec_pc,
    input  logic                  dec_halt,
    input  logic                  dec_illegal,
    input  logic [`XLEN-1:0]      rs1_data,
    input  logic [`XLEN-1:0]      rs2_data,
    output logic                  ex_valid,
    output logic [`REG_IDX_W-1:0] ex_rd,
    output logic                  ex_writes_rd,
    output logic [`XLEN-1:0]      ex_data,
    output logic [`XLEN-1:0]      ex_npc,
    output logic                  ex_halt,
    output logic                  ex_illegal
);

    logic [`XLEN-1:0] opa;
    logic [`XLEN-1:0] opb;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] result;

    // AUIPC adds to the PC, everything else to rs1
    assign opa   = (dec_alu_op == ALU_ADD_PC) ? dec_pc : rs1_data;
    assign opb   = dec_opb_imm ? dec_imm : rs2_data;
    assign shamt = opb[4:0];

    always_comb begin
        case (dec_alu_op)
            ALU_ADD, ALU_ADD_PC: result = opa + opb;
            ALU_SUB:    result = opa - opb;
            ALU_SLL:    result = opa << shamt;
            ALU_SLT:    result = {{(`XLEN - 1){1'b0}}, $signed(opa) < $signed(opb)};
            ALU_SLTU:   result = {{(`XLEN - 1){1'b0}}, opa < opb};
            ALU_XOR:    result = opa ^ opb;
            ALU_SRL:    result = opa >> shamt;
            ALU_SRA:    result = $signed(opa) >>> shamt;
            ALU_OR:     result = opa | opb;
            ALU_AND:    result = opa & opb;
            // LUI
            default:    result = opb;
        endcase
    end

    //////////////////////////////
    // Execute register
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (pipe_advance) begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (pipe_advance) begin
            ex_rd        <= dec_rd;
            ex_writes_rd <= dec_writes_rd;
            ex_data      <= result;
            ex_npc       <= dec_pc + `XLEN'd4;
            ex_halt      <= dec_halt;
            ex_illegal   <= dec_illegal;
        end
    end

endmodule

// ==== hw/result_stage.sv ====
//////////////////////////////
// Result stage
// Register file, bypassed operand reads, commit register
// and commit handshake
//////////////////////////////

`timescale 1ns/1ps

`include "cpu_defs.svh"

module result_stage (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  ex_valid,
    input  logic [`REG_IDX_W-1:0] ex_rd,
    input  logic                  ex_writes_rd,
    input  logic [`XLEN-1:0]      ex_data,
    input  logic [`XLEN-1:0]      ex_npc,
    input  logic                  ex_halt,
    input  logic                  ex_illegal,
    input  logic [`REG_IDX_W-1:0] dec_rs1,
    input  logic [`REG_IDX_W-1:0] dec_rs2,
    input  logic                  commit_ready,
    output logic [`XLEN-1:0]      rs1_data,
    output logic [`XLEN-1:0]      rs2_data,
    output logic                  pipe_advance,
    output logic                  commit_valid,
    output logic [`XLEN-1:0]      commit_npc,
    output logic [`REG_IDX_W-1:0] commit_reg,
    output logic [`XLEN-1:0]      commit_data,
    output logic                  commit_halt,
    output logic                  commit_illegal
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic             commit_writes;
    logic             commit_fire;

    // Newest pending result wins, then the committing one, then the file
    function automatic logic [`XLEN-1:0] read_operand(input logic [`REG_IDX_W-1:0] idx);
        logic [`XLEN-1:0] value;
        if (idx == `ZERO_REG) begin
            value = '0;
        end else if (ex_valid && ex_writes_rd && ex_rd == idx) begin
            value = ex_data;
        end else if (commit_valid && commit_writes && commit_reg == idx) begin
            value = commit_data;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_comb begin
        rs1_data = read_operand(dec_rs1);
        rs2_data = read_operand(dec_rs2);
    end

    //////////////////////////////
    // Commit handshake
    //////////////////////////////

    assign commit_fire  = commit_valid && commit_ready;
    // Whole pipe moves only when the commit slot frees up
    assign pipe_advance = !commit_valid || commit_ready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
        end else if (pipe_advance) begin
            commit_valid <= ex_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (pipe_advance) begin
            commit_npc     <= ex_npc;
            commit_reg     <= ex_rd;
            commit_writes  <= ex_writes_rd;
            // Nothing written, nothing reported
            commit_data    <= ex_writes_rd ? ex_data : '0;
            commit_halt    <= ex_halt;
            commit_illegal <= ex_illegal;
        end
    end

    // Architectural state updates on the commit edge
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else if (commit_fire && commit_writes) begin
            regs[commit_reg] <= commit_data;
        end
    end

endmodule

// ==== hw/cpu_core.sv ====
//////////////////////////////
// Core top level
// Decode, execute and result stages in order
//////////////////////////////

`timescale 1ns/1ps

`include "cpu_defs.svh"

module cpu_core import cpu_pkg::*; (
    input  logic                  clock,
    input  logic                  rst_n,
    // Instruction intake
    input  logic                  ff_valid,
    input  inst_word_t            ff_instr,
    input  logic [`XLEN-1:0]      ff_pc,
    output logic                  ff_consumed,
    // Commit port
    input  logic                  commit_ready,
    output logic                  commit_valid,
    output logic [`XLEN-1:0]      commit_npc,
    output logic [`REG_IDX_W-1:0] commit_reg,
    output logic [`XLEN-1:0]      commit_data,
    output logic                  commit_halt,
    output logic                  commit_illegal
);

    //////////////////////////////
    // Stage wires
    //////////////////////////////

    logic pipe_advance;

    // Decode register
    logic                  dec_valid;
    alu_op_t               dec_alu_op;
    logic [`REG_IDX_W-1:0] dec_rs1;
    logic [`REG_IDX_W-1:0] dec_rs2;
    logic [`REG_IDX_W-1:0] dec_rd;
    logic                  dec_writes_rd;
    logic                  dec_opb_imm;
    logic [`XLEN-1:0]      dec_imm;
    logic [`XLEN-1:0]      dec_pc;
    logic                  dec_halt;
    logic                  dec_illegal;

    // Bypassed operands
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;

    // Execute register
    logic                  ex_valid;
    logic [`REG_IDX_W-1:0] ex_rd;
    logic                  ex_writes_rd;
    logic [`XLEN-1:0]      ex_data;
    logic [`XLEN-1:0]      ex_npc;
    logic                  ex_halt;
    logic                  ex_illegal;

    decode_stage i_decode_stage (
        .clock         (clock),
        .rst_n         (rst_n),
        .ff_valid      (ff_valid),
        .ff_instr      (ff_instr),
        .ff_pc         (ff_pc),
        .pipe_advance  (pipe_advance),
        .ff_consumed   (ff_consumed),
        .dec_valid     (dec_valid),
        .dec_alu_op    (dec_alu_op),
        .dec_rs1       (dec_rs1),
        .dec_rs2       (dec_rs2),
        .dec_rd        (dec_rd),
        .dec_writes_rd (dec_writes_rd),
        .dec_opb_imm   (dec_opb_imm),
        .dec_imm       (dec_imm),
        .dec_pc        (dec_pc),
        .dec_halt      (dec_halt),
        .dec_illegal   (dec_illegal)
    );

    execute_stage i_execute_stage (
        .clock         (clock),
        .rst_n         (rst_n),
        .pipe_advance  (pipe_advance),
        .dec_valid     (dec_valid),
        .dec_alu_op    (dec_alu_op),
        .dec_rd        (dec_rd),
        .dec_writes_rd (dec_writes_rd),
        .dec_opb_imm   (dec_opb_imm),
        .dec_imm       (dec_imm),
        .dec_pc        (dec_pc),
        .dec_halt      (dec_halt),
        .dec_illegal   (dec_illegal),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .ex_valid      (ex_valid),
        .ex_rd         (ex_rd),
        .ex_writes_rd  (ex_writes_rd),
        .ex_data       (ex_data),
        .ex_npc        (ex_npc),
        .ex_halt       (ex_halt),
        .ex_illegal    (ex_illegal)
    );

    // Read indices come straight from the decode register
    result_stage i_result_stage (
        .clock          (clock),
        .rst_n          (rst_n),
        .ex_valid       (ex_valid),
        .ex_rd          (ex_rd),
        .ex_writes_rd   (ex_writes_rd),
        .ex_data        (ex_data),
        .ex_npc         (ex_npc),
        .ex_halt        (ex_halt),
        .ex_illegal     (ex_illegal),
        .dec_rs1        (dec_rs1),
        .dec_rs2        (dec_rs2),
        .commit_ready   (commit_ready),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .pipe_advance   (pipe_advance),
        .commit_valid   (commit_valid),
        .commit_npc     (commit_npc),
        .commit_reg     (commit_reg),
        .commit_data    (commit_data),
        .commit_halt    (commit_halt),
        .commit_illegal (commit_illegal)
    );

endmodule

// ==== tb/cpu_core_chk.sv ====
//////////////////////////////
// Core handshake checker
// Bound into the core top level
//////////////////////////////

`timescale 1ns/1ps

`include "cpu_defs.svh"

module cpu_core_chk (
    input logic                  clock,
    input logic                  rst_n,
    input logic                  ff_valid,
    input logic                  ff_consumed,
    input logic                  dec_valid,
    input logic                  commit_ready,
    input logic                  commit_valid,
    input logic [`XLEN-1:0]      commit_npc,
    input logic [`REG_IDX_W-1:0] commit_reg,
    input logic [`XLEN-1:0]      commit_data,
    input logic                  commit_halt,
    input logic                  commit_illegal
);

    // Stalled commit holds every output
    property commit_held;
        @(posedge clock) disable iff (!rst_n)
            commit_valid && !commit_ready |=>
                commit_valid && $stable(commit_npc) && $stable(commit_reg) &&
                $stable(commit_data) && $stable(commit_halt) && $stable(commit_illegal);
    endproperty

    assert property (commit_held)
        else $error("Commit outputs changed while the commit port was stalled");

    // Full decode slot behind a stalled commit takes no offer
    assert property (@(posedge clock) disable iff (!rst_n)
        ff_valid && dec_valid && commit_valid && !commit_ready |-> !ff_consumed)
        else $error("ff_consumed high while the pipeline was stalled");

    // Quiet handshakes in reset
    assert property (@(posedge clock) !rst_n |-> !ff_consumed)
        else $error("ff_consumed high during reset");

    assert property (@(posedge clock) !rst_n |=> !commit_valid)
        else $error("commit_valid high after a reset edge");

endmodule

bind cpu_core cpu_core_chk i_cpu_core_chk (
    .clock          (clock),
    .rst_n          (rst_n),
    .ff_valid       (ff_valid),
    .ff_consumed    (ff_consumed),
    .dec_valid      (dec_valid),
    .commit_ready   (commit_ready),
    .commit_valid   (commit_valid),
    .commit_npc     (commit_npc),
    .commit_reg     (commit_reg),
    .commit_data    (commit_data),
    .commit_halt    (commit_halt),
    .commit_illegal (commit_illegal)
);

// ==== tb/cpu_core_tb.sv ====
//////////////////////////////
// Core testbench
// Table-driven intake, in-order commit checks,
// random back-pressure and latency measurement
//////////////////////////////

`timescale 1ns/1ps

`include "cpu_defs.svh"

module cpu_core_tb;

    localparam int          RESET_CYCLES = 5;
    localparam logic [31:0] PC_BASE      = 32'h0000_0100;
    // LUI entry, reused for the latency run
    localparam int          LAT_IDX      = 13;

    logic                  clock = 1'b0;
    logic                  rst_n;
    logic                  ff_valid;
    logic [`XLEN-1:0]      ff_instr;
    logic [`XLEN-1:0]      ff_pc;
    logic                  ff_consumed;
    logic                  commit_ready = 1'b1;
    logic                  commit_valid;
    logic [`XLEN-1:0]      commit_npc;
    logic [`REG_IDX_W-1:0] commit_reg;
    logic [`XLEN-1:0]      commit_data;
    logic                  commit_halt;
    logic                  commit_illegal;

    logic   ready_random = 1'b0;
    logic   table_ready  = 1'b0;
    integer seed         = 32'h08b4_9011;

    // Stimulus and expectation table
    string       names[$];
    logic [31:0] words[$];
    logic [31:0] pcs[$];
    int          exp_reg[$];
    logic [31:0] exp_data[$];
    logic        exp_halt[$];
    logic        exp_ill[$];

    cpu_core i_cpu_core (
        .clock          (clock),
        .rst_n          (rst_n),
        .ff_valid       (ff_valid),
        .ff_instr       (ff_instr),
        .ff_pc          (ff_pc),
        .ff_consumed    (ff_consumed),
        .commit_ready   (commit_ready),
        .commit_valid   (commit_valid),
        .commit_npc     (commit_npc),
        .commit_reg     (commit_reg),
        .commit_data    (commit_data),
        .commit_halt    (commit_halt),
        .commit_illegal (commit_illegal)
    );

    always #4 clock = ~clock;

    // Commit back-pressure, low about one cycle in four when enabled
    always @(posedge clock) begin
        if (!rst_n || !ready_random) begin
            commit_ready <= 1'b1;
        end else begin
            commit_ready <= (($random(seed) & 32'd3) != 32'd0);
        end
    end

    //////////////////////////////
    // RV32I encoders
    //////////////////////////////

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                          input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1,
                                          input logic [2:0] f3, input logic [6:0] opc);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_u(input int imm, input int rd, input logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    // PC follows table position
    task automatic add_entry(input string name, input logic [31:0] word, input int rd,
                             input logic [31:0] data, input logic halt, input logic illegal);
        pcs.push_back(PC_BASE + 4 * names.size());
        names.push_back(name);
        words.push_back(word);
        exp_reg.push_back(rd);
        exp_data.push_back(data);
        exp_halt.push_back(halt);
        exp_ill.push_back(illegal);
    endtask

    task automatic build_table();
        // ALU coverage, x1 = 5 and x2 = -3 as base operands
        add_entry("addi", enc_i(5, 0, `F3_ADD, 1, `OPC_OP_IMM), 1, 32'h0000_0005, 1'b0, 1'b0);
        add_entry("addi_neg", enc_i(-3, 0, `F3_ADD, 2, `OPC_OP_IMM), 2, 32'hFFFF_FFFD, 1'b0, 1'b0);
        add_entry("add", enc_r(7'd0, 2, 1, `F3_ADD, 3), 3, 32'h0000_0002, 1'b0, 1'b0);
        add_entry("sub", enc_r(`F7_ALT, 2, 1, `F3_ADD, 4), 4, 32'h0000_0008, 1'b0, 1'b0);
        add_entry("xori", enc_i('hF0, 1, `F3_XOR, 5, `OPC_OP_IMM), 5, 32'h0000_00F5, 1'b0, 1'b0);
        add_entry("or", enc_r(7'd0, 2, 1, `F3_OR, 6), 6, 32'hFFFF_FFFD, 1'b0, 1'b0);
        add_entry("and", enc_r(7'd0, 2, 1, `F3_AND, 7), 7, 32'h0000_0005, 1'b0, 1'b0);
        add_entry("slli", enc_i(4, 1, `F3_SLL, 8, `OPC_OP_IMM), 8, 32'h0000_0050, 1'b0, 1'b0);
        add_entry("srai_neg", enc_i('h401, 2, `F3_SR, 9, `OPC_OP_IMM), 9, 32'hFFFF_FFFE, 1'b0, 1'b0);
        add_entry("srli", enc_i(28, 2, `F3_SR, 10, `OPC_OP_IMM), 10, 32'h0000_000F, 1'b0, 1'b0);
        add_entry("slt", enc_r(7'd0, 1, 2, `F3_SLT, 11), 11, 32'h0000_0001, 1'b0, 1'b0);
        add_entry("sltu", enc_r(7'd0, 1, 2, `F3_SLTU, 12), 12, 32'h0000_0000, 1'b0, 1'b0);
        add_entry("sltiu", enc_i(-1, 1, `F3_SLTU, 13, `OPC_OP_IMM), 13, 32'h0000_0001, 1'b0, 1'b0);
        add_entry("lui", enc_u('h12345, 14, `OPC_LUI), 14, 32'h1234_5000, 1'b0, 1'b0);
        add_entry("auipc", enc_u(1, 15, `OPC_AUIPC), 15, 32'h0000_1138, 1'b0, 1'b0);
        // Register shift amounts use only the low 5 bits
        add_entry("sll", enc_r(7'd0, 8, 1, `F3_SLL, 16), 16, 32'h0005_0000, 1'b0, 1'b0);
        add_entry("sra_neg", enc_r(`F7_ALT, 10, 2, `F3_SR, 17), 17, 32'hFFFF_FFFF, 1'b0, 1'b0);
        add_entry("andi", enc_i('hFF, 2, `F3_AND, 18, `OPC_OP_IMM), 18, 32'h0000_00FD, 1'b0, 1'b0);
        add_entry("ori", enc_i(-16, 1, `F3_OR, 19, `OPC_OP_IMM), 19, 32'hFFFF_FFF5, 1'b0, 1'b0);
        // Back-to-back dependency chain on x20
        add_entry("chain_0", enc_i(1, 0, `F3_ADD, 20, `OPC_OP_IMM), 20, 32'h0000_0001, 1'b0, 1'b0);
        add_entry("chain_1", enc_r(7'd0, 20, 20, `F3_ADD, 20), 20, 32'h0000_0002, 1'b0, 1'b0);
        add_entry("chain_2", enc_r(7'd0, 20, 20, `F3_ADD, 20), 20, 32'h0000_0004, 1'b0, 1'b0);
        add_entry("chain_3", enc_i(3, 20, `F3_ADD, 20, `OPC_OP_IMM), 20, 32'h0000_0007, 1'b0, 1'b0);
        add_entry("chain_4", enc_r(`F7_ALT, 1, 20, `F3_ADD, 21), 21, 32'h0000_0002, 1'b0, 1'b0);
        add_entry("chain_5", enc_r(7'd0, 20, 21, `F3_XOR, 21), 21, 32'h0000_0005, 1'b0, 1'b0);
        // Writes to x0 vanish
        add_entry("write_x0", enc_i(7, 1, `F3_ADD, 0, `OPC_OP_IMM), 0, 32'h0000_0000, 1'b0, 1'b0);
        add_entry("read_x0", enc_r(7'd0, 1, 0, `F3_ADD, 22), 22, 32'h0000_0005, 1'b0, 1'b0);
        // Unsupported encodings, x1 must survive the load
        add_entry("ill_load", enc_i(0, 0, 3'b010, 1, 7'b0000011), 1, 32'h0, 1'b0, 1'b1);
        add_entry("x1_kept", enc_i(0, 1, `F3_ADD, 23, `OPC_OP_IMM), 23, 32'h0000_0005, 1'b0, 1'b0);
        add_entry("ill_store", enc_s(0, 1, 2, 3'b010, `OPC_STORE), 0, 32'h0, 1'b0, 1'b1);
        add_entry("ill_mul", enc_r(7'd1, 1, 1, `F3_ADD, 25), 25, 32'h0, 1'b0, 1'b1);
        add_entry("ecall", enc_i(0, 0, 3'b000, 0, `OPC_SYSTEM), 0, 32'h0, 1'b1, 1'b0);
        add_entry("add_upper", enc_r(7'd0, 15, 14, `F3_ADD, 24), 24, 32'h1234_6138, 1'b0, 1'b0);
        add_entry("ebreak", enc_i(1, 0, 3'b000, 0, `OPC_SYSTEM), 0, 32'h0, 1'b1, 1'b0);
    endtask

    //////////////////////////////
    // Checking
    //////////////////////////////

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected %h, actual %h", test, field, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Mismatch in %s", test);
        end
    endtask

    // Offer each word until the intake takes it
    task automatic feed_table();
        @(posedge clock);
        for (int i = 0; i < names.size(); i++) begin
            ff_valid <= 1'b1;
            ff_instr <= words[i];
            ff_pc    <= pcs[i];
            @(negedge clock);
            while (!ff_consumed) begin
                @(negedge clock);
            end
            @(posedge clock);
        end
        ff_valid <= 1'b0;
    endtask

    // Sampled mid-cycle, the commit fires on the following edge
    task automatic collect_table(input string tag);
        for (int i = 0; i < names.size(); i++) begin
            @(negedge clock);
            while (!(commit_valid && commit_ready)) begin
                @(negedge clock);
            end
            check_value({tag, "/", names[i]}, "commit_reg", exp_reg[i], {27'd0, commit_reg});
            check_value({tag, "/", names[i]}, "commit_data", exp_data[i], commit_data);
            check_value({tag, "/", names[i]}, "commit_halt", {31'd0, exp_halt[i]},
                        {31'd0, commit_halt});
            check_value({tag, "/", names[i]}, "commit_illegal", {31'd0, exp_ill[i]},
                        {31'd0, commit_illegal});
            check_value({tag, "/", names[i]}, "commit_npc", pcs[i] + 32'd4, commit_npc);
        end
    endtask

    task automatic run_pass(input string tag);
        fork
            feed_table();
            collect_table(tag);
        join
    endtask

    // Nothing may commit beyond the table
    task automatic check_drained(input string tag);
        repeat (4) begin
            @(negedge clock);
            check_value({tag, "/drain"}, "commit_valid", 32'd0, {31'd0, commit_valid});
        end
    endtask

    // Take edge counts as the first
    task automatic measure_latency(input int idx);
        int edges;
        @(posedge clock);
        ff_valid <= 1'b1;
        ff_instr <= words[idx];
        ff_pc    <= pcs[idx];
        @(negedge clock);
        check_value("latency", "ff_consumed", 32'd1, {31'd0, ff_consumed});
        @(posedge clock);
        ff_valid <= 1'b0;
        edges = 1;
        @(negedge clock);
        while (!commit_valid && edges < 8) begin
            @(posedge clock);
            edges++;
            @(negedge clock);
        end
        check_value("latency", "edges", 32'd3, edges);
        check_value("latency", "commit_data", exp_data[idx], commit_data);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        rst_n    = 1'b0;
        ff_valid = 1'b0;
        ff_instr = '0;
        ff_pc    = '0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;

        // Full rate, commit_ready held high
        run_pass("full_rate");
        check_drained("full_rate");

        // Same table under random stalls
        @(posedge clock);
        ready_random <= 1'b1;
        run_pass("backpressure");
        @(posedge clock);
        ready_random <= 1'b0;
        check_drained("backpressure");

        measure_latency(LAT_IDX);
        check_drained("latency");

        $display("TEST OK");
        $finish;
    end

    // Watchdog scaled by table length
    initial begin
        int limit;
        wait (table_ready);
        limit = RESET_CYCLES + 20 * names.size();
        repeat (limit) @(posedge clock);
        $display("Timeout: the run did not complete within %0d clock cycles", limit);
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== build.f ====
+incdir+common
common/cpu_pkg.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/cpu_core.sv
tb/cpu_core_chk.sv
tb/cpu_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and scan the log for the result

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module cpu_core_tb \
    --Mdir "$build_dir" \
    -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/Vcpu_core_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST OK" "$log_file"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation did not report a pass"
exit 1
